// File: riscv_de_consts.svh
`ifndef RISCV_DE_CONSTS_SVH
`define RISCV_DE_CONSTS_SVH

`define RISCV_DE_XLEN           64                      // data and pc width
`define RISCV_DE_NREGS          32                      // integer register count

// base opcodes, inst[6:0]
`define RISCV_DE_OP_LUI         7'b0110111
`define RISCV_DE_OP_AUIPC       7'b0010111
`define RISCV_DE_OP_JAL         7'b1101111
`define RISCV_DE_OP_JALR        7'b1100111
`define RISCV_DE_OP_BRANCH      7'b1100011
`define RISCV_DE_OP_LOAD        7'b0000011
`define RISCV_DE_OP_STORE       7'b0100011
`define RISCV_DE_OP_OPIMM       7'b0010011
`define RISCV_DE_OP_OPIMM32     7'b0011011
`define RISCV_DE_OP_OP          7'b0110011
`define RISCV_DE_OP_OP32        7'b0111011

`define RISCV_DE_F7_MULDIV      7'b0000001              // M extension
`define RISCV_DE_F3_SR          3'b101                  // srl/sra share funct3

// funcsel encodings
`define RISCV_DE_FS_ALU         2'b00
`define RISCV_DE_FS_MUL         2'b01
`define RISCV_DE_FS_DIV         2'b10

// resultsrc encodings
`define RISCV_DE_RS_ALU         2'b00
`define RISCV_DE_RS_MEM         2'b01
`define RISCV_DE_RS_PC4         2'b10

`endif

// File: riscv_de_pkg.sv
`include "riscv_de_consts.svh"

package riscv_de_pkg;

        typedef struct packed {
                logic [6:0]     funct7;
                logic [4:0]     rs2;
                logic [4:0]     rs1;
                logic [2:0]     funct3;
                logic [4:0]     rd;
                logic [6:0]     opcode;
        } riscv_de_r_s;

        typedef struct packed {
                logic [11:0]    imm;
                logic [4:0]     rs1;
                logic [2:0]     funct3;
                logic [4:0]     rd;
                logic [6:0]     opcode;
        } riscv_de_i_s;

        typedef struct packed {
                logic [6:0]     imm_11_5;
                logic [4:0]     rs2;
                logic [4:0]     rs1;
                logic [2:0]     funct3;
                logic [4:0]     imm_4_0;
                logic [6:0]     opcode;
        } riscv_de_s_s;

        typedef struct packed {
                logic           imm_12;
                logic [5:0]     imm_10_5;
                logic [4:0]     rs2;
                logic [4:0]     rs1;
                logic [2:0]     funct3;
                logic [3:0]     imm_4_1;
                logic           imm_11;
                logic [6:0]     opcode;
        } riscv_de_b_s;

        typedef struct packed {
                logic [19:0]    imm_31_12;
                logic [4:0]     rd;
                logic [6:0]     opcode;
        } riscv_de_u_s;

        typedef struct packed {
                logic           imm_20;
                logic [9:0]     imm_10_1;
                logic           imm_11;
                logic [7:0]     imm_19_12;
                logic [4:0]     rd;
                logic [6:0]     opcode;
        } riscv_de_j_s;

        // one fetched word, seen through each base format
        typedef union packed {
                riscv_de_r_s    r;
                riscv_de_i_s    i;
                riscv_de_s_s    s;
                riscv_de_b_s    b;
                riscv_de_u_s    u;
                riscv_de_j_s    j;
        } riscv_de_inst_u;

        typedef struct packed {
                logic [3:0]     b_condition;            // {branch, funct3}
                logic           oprnd1sel;              // 1: pc
                logic           oprnd2sel;              // 1: immediate
                logic [1:0]     storesrc;
                logic [5:0]     alucontrol;             // {lui, word, alt, funct3}
                logic [2:0]     mulctrl;
                logic [2:0]     divctrl;
                logic [1:0]     funcsel;
                logic           memwrite;
                logic [2:0]     memext;
                logic [1:0]     resultsrc;
                logic           regwrite;
                logic           jump;
        } riscv_de_ctrl_s;

        typedef struct packed {
                logic                                   regwrite;
                logic [$clog2(`RISCV_DE_NREGS)-1:0]     rdaddr;
                logic [`RISCV_DE_XLEN-1:0]              data;
        } riscv_de_wb_s;

        typedef struct packed {
                logic [`RISCV_DE_XLEN-1:0]              pc;
                logic [`RISCV_DE_XLEN-1:0]              pcplus4;
                logic [$clog2(`RISCV_DE_NREGS)-1:0]     rs1addr;
                logic [`RISCV_DE_XLEN-1:0]              rs1data;
                logic [$clog2(`RISCV_DE_NREGS)-1:0]     rs2addr;
                logic [`RISCV_DE_XLEN-1:0]              rs2data;
                logic [$clog2(`RISCV_DE_NREGS)-1:0]     rdaddr;
                logic [`RISCV_DE_XLEN-1:0]              extendedimm;
                logic [6:0]                             opcode;
                riscv_de_ctrl_s                         ctrl;
                logic [31:0]                            inst;
                logic [15:0]                            cinst;  // trace only
        } riscv_de_de_s;

endpackage

// File: riscv_de_ctrl_dec.sv
`timescale 1ns/100ps
`include "riscv_de_consts.svh"

module riscv_de_ctrl_dec (
        input  riscv_de_pkg::riscv_de_inst_u    i_riscv_de_inst,
        output riscv_de_pkg::riscv_de_ctrl_s    o_riscv_de_ctrl,
        output logic                            o_riscv_de_illegal
);

        logic [6:0]     opcode;
        logic [2:0]     funct3;
        logic [6:0]     funct7;
        logic           is_word;
        logic           shift_alt;

        assign opcode    = i_riscv_de_inst.r.opcode;
        assign funct3    = i_riscv_de_inst.r.funct3;
        assign funct7    = i_riscv_de_inst.r.funct7;
        assign is_word   = (opcode == `RISCV_DE_OP_OP32) || (opcode == `RISCV_DE_OP_OPIMM32);
        assign shift_alt = (funct3 == `RISCV_DE_F3_SR) && funct7[5];   // srai/sraiw only

        always_comb
        begin
                o_riscv_de_ctrl    = '0;
                o_riscv_de_illegal = 1'b0;
                case (opcode)
                `RISCV_DE_OP_OP, `RISCV_DE_OP_OP32:
                begin
                        o_riscv_de_ctrl.regwrite = 1'b1;
                        if (funct7 == `RISCV_DE_F7_MULDIV)
                        begin
                                o_riscv_de_ctrl.alucontrol[4] = is_word;
                                if (!funct3[2])
                                begin
                                        o_riscv_de_ctrl.funcsel = `RISCV_DE_FS_MUL;
                                        o_riscv_de_ctrl.mulctrl = funct3;
                                end
                                else
                                begin
                                        o_riscv_de_ctrl.funcsel = `RISCV_DE_FS_DIV;
                                        o_riscv_de_ctrl.divctrl = funct3 - 3'd4;
                                end
                        end
                        else
                        begin
                                o_riscv_de_ctrl.alucontrol = {1'b0, is_word, funct7[5], funct3};
                        end
                end
                `RISCV_DE_OP_OPIMM, `RISCV_DE_OP_OPIMM32:
                begin
                        o_riscv_de_ctrl.regwrite   = 1'b1;
                        o_riscv_de_ctrl.oprnd2sel  = 1'b1;
                        o_riscv_de_ctrl.alucontrol = {1'b0, is_word, shift_alt, funct3};
                end
                `RISCV_DE_OP_LOAD:
                begin
                        o_riscv_de_ctrl.regwrite  = 1'b1;
                        o_riscv_de_ctrl.oprnd2sel = 1'b1;
                        o_riscv_de_ctrl.resultsrc = `RISCV_DE_RS_MEM;
                        o_riscv_de_ctrl.memext    = funct3;
                end
                `RISCV_DE_OP_STORE:
                begin
                        o_riscv_de_ctrl.memwrite  = 1'b1;
                        o_riscv_de_ctrl.oprnd2sel = 1'b1;
                        o_riscv_de_ctrl.storesrc  = funct3[1:0];    // sb/sh/sw/sd
                end
                `RISCV_DE_OP_BRANCH:
                begin
                        o_riscv_de_ctrl.b_condition = {1'b1, funct3};
                end
                `RISCV_DE_OP_JAL:
                begin
                        o_riscv_de_ctrl.jump      = 1'b1;
                        o_riscv_de_ctrl.regwrite  = 1'b1;
                        o_riscv_de_ctrl.resultsrc = `RISCV_DE_RS_PC4;
                        o_riscv_de_ctrl.oprnd1sel = 1'b1;
                end
                `RISCV_DE_OP_JALR:
                begin
                        o_riscv_de_ctrl.jump      = 1'b1;
                        o_riscv_de_ctrl.regwrite  = 1'b1;
                        o_riscv_de_ctrl.resultsrc = `RISCV_DE_RS_PC4;
                end
                `RISCV_DE_OP_LUI:
                begin
                        o_riscv_de_ctrl.regwrite      = 1'b1;
                        o_riscv_de_ctrl.oprnd2sel     = 1'b1;
                        o_riscv_de_ctrl.alucontrol[5] = 1'b1;   // pass immediate
                end
                `RISCV_DE_OP_AUIPC:
                begin
                        o_riscv_de_ctrl.regwrite  = 1'b1;
                        o_riscv_de_ctrl.oprnd1sel = 1'b1;
                        o_riscv_de_ctrl.oprnd2sel = 1'b1;
                end
                default:
                begin
                        o_riscv_de_illegal = 1'b1;              // csr, fence, system, unknown
                end
                endcase
        end

        // no opcode both writes memory and the register file
        always_comb
        begin
                assert (!(o_riscv_de_ctrl.memwrite && o_riscv_de_ctrl.regwrite))
                else $error("decoder raised memwrite and regwrite together");
        end

endmodule

// File: riscv_de_immext.sv
`timescale 1ns/100ps
`include "riscv_de_consts.svh"

module riscv_de_immext (
        input  riscv_de_pkg::riscv_de_inst_u    i_riscv_de_inst,
        output logic [`RISCV_DE_XLEN-1:0]       o_riscv_de_extendedimm
);

        localparam int XL = `RISCV_DE_XLEN;

        logic sign;

        assign sign = i_riscv_de_inst.r.funct7[6];      // inst[31] in every format

        always_comb
        begin
                case (i_riscv_de_inst.r.opcode)
                `RISCV_DE_OP_OPIMM, `RISCV_DE_OP_OPIMM32, `RISCV_DE_OP_LOAD, `RISCV_DE_OP_JALR:
                        o_riscv_de_extendedimm = {{(XL-12){sign}}, i_riscv_de_inst.i.imm};
                `RISCV_DE_OP_STORE:
                        o_riscv_de_extendedimm = {{(XL-12){sign}}, i_riscv_de_inst.s.imm_11_5,
                                                  i_riscv_de_inst.s.imm_4_0};
                `RISCV_DE_OP_BRANCH:
                        o_riscv_de_extendedimm = {{(XL-13){sign}}, i_riscv_de_inst.b.imm_12,
                                                  i_riscv_de_inst.b.imm_11,
                                                  i_riscv_de_inst.b.imm_10_5,
                                                  i_riscv_de_inst.b.imm_4_1, 1'b0};
                `RISCV_DE_OP_LUI, `RISCV_DE_OP_AUIPC:
                        o_riscv_de_extendedimm = {{(XL-32){sign}}, i_riscv_de_inst.u.imm_31_12,
                                                  12'b0};
                `RISCV_DE_OP_JAL:
                        o_riscv_de_extendedimm = {{(XL-21){sign}}, i_riscv_de_inst.j.imm_20,
                                                  i_riscv_de_inst.j.imm_19_12,
                                                  i_riscv_de_inst.j.imm_11,
                                                  i_riscv_de_inst.j.imm_10_1, 1'b0};
                default:
                        o_riscv_de_extendedimm = '0;
                endcase
        end

endmodule

// File: riscv_de_regfile.sv
`timescale 1ns/100ps
`include "riscv_de_consts.svh"

module riscv_de_regfile (
        input  logic                                    i_riscv_de_clk,
        input  logic                                    i_riscv_de_rst,
        input  logic [$clog2(`RISCV_DE_NREGS)-1:0]      i_riscv_de_rs1addr,
        input  logic [$clog2(`RISCV_DE_NREGS)-1:0]      i_riscv_de_rs2addr,
        input  riscv_de_pkg::riscv_de_wb_s              i_riscv_de_wb,
        output logic [`RISCV_DE_XLEN-1:0]               o_riscv_de_rs1data,
        output logic [`RISCV_DE_XLEN-1:0]               o_riscv_de_rs2data
);

        logic [`RISCV_DE_XLEN-1:0] regs [1:`RISCV_DE_NREGS-1];  // x0 not stored
        logic                      wr_en;

        assign wr_en = i_riscv_de_wb.regwrite && (i_riscv_de_wb.rdaddr != '0);

        always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
        begin
                if (i_riscv_de_rst)
                begin
                        for (int k = 1; k < `RISCV_DE_NREGS; k++)
                        begin
                                regs[k] <= '0;
                        end
                end
                else if (wr_en)
                begin
                        regs[i_riscv_de_wb.rdaddr] <= i_riscv_de_wb.data;
                end
        end

        // same-cycle writeback wins over the stored value
        assign o_riscv_de_rs1data = (i_riscv_de_rs1addr == '0) ? '0 :
                (wr_en && (i_riscv_de_wb.rdaddr == i_riscv_de_rs1addr)) ? i_riscv_de_wb.data :
                regs[i_riscv_de_rs1addr];

        assign o_riscv_de_rs2data = (i_riscv_de_rs2addr == '0) ? '0 :
                (wr_en && (i_riscv_de_wb.rdaddr == i_riscv_de_rs2addr)) ? i_riscv_de_wb.data :
                regs[i_riscv_de_rs2addr];

        // x0 still reads zero in the cycle after a write aimed at it
        assert property (@(posedge i_riscv_de_clk) disable iff (i_riscv_de_rst)
                (i_riscv_de_wb.regwrite && (i_riscv_de_wb.rdaddr == '0))
                |=> ((i_riscv_de_rs1addr != '0) || (o_riscv_de_rs1data == '0)))
        else $error("write to x0 changed its read value");

endmodule

// File: riscv_de_ppreg.sv
`timescale 1ns/100ps

module riscv_de_ppreg (
        input  logic                            i_riscv_de_clk,
        input  logic                            i_riscv_de_rst,
        input  logic                            i_riscv_de_flush,
        input  riscv_de_pkg::riscv_de_de_s      i_riscv_de_d,
        output riscv_de_pkg::riscv_de_de_s      o_riscv_de_e
);

        always_ff @(posedge i_riscv_de_clk or posedge i_riscv_de_rst)
        begin
                if (i_riscv_de_rst)
                begin
                        o_riscv_de_e <= '0;
                end
                else if (i_riscv_de_flush)
                begin
                        o_riscv_de_e <= '0;                     // bubble
                end
                else
                begin
                        o_riscv_de_e <= i_riscv_de_d;
                end
        end

        // a flushed slot must not write back, store or redirect fetch
        assert property (@(posedge i_riscv_de_clk) disable iff (i_riscv_de_rst)
                i_riscv_de_flush |=> !(o_riscv_de_e.ctrl.regwrite ||
                                       o_riscv_de_e.ctrl.memwrite ||
                                       o_riscv_de_e.ctrl.jump))
        else $error("side effect leaked through a flushed slot");

endmodule

// File: riscv_de_stage.sv
`timescale 1ns/100ps
`include "riscv_de_consts.svh"

module riscv_de_stage (
        input  logic                            i_riscv_de_clk,
        input  logic                            i_riscv_de_rst,
        input  riscv_de_pkg::riscv_de_inst_u    i_riscv_de_inst,
        input  logic [15:0]                     i_riscv_de_cinst,
        input  logic [`RISCV_DE_XLEN-1:0]       i_riscv_de_pc,
        input  logic [`RISCV_DE_XLEN-1:0]       i_riscv_de_pcplus4,
        input  logic                            i_riscv_de_flush,
        input  riscv_de_pkg::riscv_de_wb_s      i_riscv_de_wb,
        output riscv_de_pkg::riscv_de_de_s      o_riscv_de_e
);

        riscv_de_pkg::riscv_de_ctrl_s   ctrl;
        logic [`RISCV_DE_XLEN-1:0]      extendedimm;
        logic [`RISCV_DE_XLEN-1:0]      rs1data;
        logic [`RISCV_DE_XLEN-1:0]      rs2data;
        riscv_de_pkg::riscv_de_de_s     de_d;

        riscv_de_ctrl_dec u_ctrl_dec (
                .i_riscv_de_inst        (i_riscv_de_inst),
                .o_riscv_de_ctrl        (ctrl),
                .o_riscv_de_illegal     ()
        );

        riscv_de_immext u_immext (
                .i_riscv_de_inst        (i_riscv_de_inst),
                .o_riscv_de_extendedimm (extendedimm)
        );

        riscv_de_regfile u_regfile (
                .i_riscv_de_clk         (i_riscv_de_clk),
                .i_riscv_de_rst         (i_riscv_de_rst),
                .i_riscv_de_rs1addr     (i_riscv_de_inst.r.rs1),
                .i_riscv_de_rs2addr     (i_riscv_de_inst.r.rs2),
                .i_riscv_de_wb          (i_riscv_de_wb),
                .o_riscv_de_rs1data     (rs1data),
                .o_riscv_de_rs2data     (rs2data)
        );

        assign de_d = '{pc:          i_riscv_de_pc,
                        pcplus4:     i_riscv_de_pcplus4,
                        rs1addr:     i_riscv_de_inst.r.rs1,
                        rs1data:     rs1data,
                        rs2addr:     i_riscv_de_inst.r.rs2,
                        rs2data:     rs2data,
                        rdaddr:      i_riscv_de_inst.r.rd,
                        extendedimm: extendedimm,
                        opcode:      i_riscv_de_inst.r.opcode,
                        ctrl:        ctrl,
                        inst:        i_riscv_de_inst,
                        cinst:       i_riscv_de_cinst};

        riscv_de_ppreg u_ppreg (
                .i_riscv_de_clk         (i_riscv_de_clk),
                .i_riscv_de_rst         (i_riscv_de_rst),
                .i_riscv_de_flush       (i_riscv_de_flush),
                .i_riscv_de_d           (de_d),
                .o_riscv_de_e           (o_riscv_de_e)
        );

endmodule

// File: riscv_de_tb_tests.svh
`ifndef RISCV_DE_TB_TESTS_SVH
`define RISCV_DE_TB_TESTS_SVH

localparam logic [6:0] LEGAL_OPS [11] = '{`RISCV_DE_OP_LUI, `RISCV_DE_OP_AUIPC,
        `RISCV_DE_OP_JAL, `RISCV_DE_OP_JALR, `RISCV_DE_OP_BRANCH, `RISCV_DE_OP_LOAD,
        `RISCV_DE_OP_STORE, `RISCV_DE_OP_OPIMM, `RISCV_DE_OP_OPIMM32, `RISCV_DE_OP_OP,
        `RISCV_DE_OP_OP32};

localparam logic [6:0] BAD_OPS [5] = '{7'b1110011, 7'b0001111, 7'b1111111, 7'b0000000,
        7'b1010111};                                    // system, fence, reserved

task automatic test_reset();
        check_bundle('0);                               // straight out of reset
        @(posedge clk);
        @(negedge clk);
        check_bundle('0);                               // zero word is a zero bundle
endtask

task automatic test_regfile();
        logic [4:0]     rd;
        logic [4:0]     rs1;
        logic [4:0]     rs2;
        logic [63:0]    data;
        for (int n = 0; n < 40; n++)
        begin
                rd   = 5'($urandom);
                data = {$urandom, $urandom};
                rs1  = (n % 4 == 0) ? rd : 5'($urandom);        // same-cycle read
                rs2  = (n % 4 == 2) ? rd : 5'($urandom);
                issue({7'd0, rs2, rs1, 3'd0, 5'($urandom), `RISCV_DE_OP_OP}, 1'b0, 1'b1, rd, data);
        end
        issue({7'd0, 5'd0, 5'd0, 3'd0, 5'd1, `RISCV_DE_OP_OP}, 1'b0, 1'b1, 5'd0, '1);
        issue({7'd0, 5'd0, 5'd0, 3'd0, 5'd1, `RISCV_DE_OP_OP}, 1'b0, 1'b0, 5'd0, '0);
endtask

task automatic test_formats();
        for (int k = 0; k < 11; k++)
        begin
                for (int n = 0; n < 10; n++)
                        issue(rand_word(LEGAL_OPS[k]), 1'b0, 1'b0, 5'd0, '0);
        end
endtask

task automatic test_muldiv();
        logic [6:0] op;
        for (int n = 0; n < 40; n++)
        begin
                op = (n % 2 == 0) ? `RISCV_DE_OP_OP : `RISCV_DE_OP_OP32;
                issue({7'd1, 18'($urandom), op}, 1'b0, 1'b0, 5'd0, '0);
        end
endtask

task automatic test_flush();
        for (int n = 0; n < 12; n++)
                issue(rand_word(LEGAL_OPS[n % 11]), n == 5, 1'b0, 5'd0, '0);
endtask

task automatic test_illegal();
        for (int n = 0; n < 15; n++)
        begin
                issue(rand_word(BAD_OPS[n % 5]), 1'b0, 1'b0, 5'd0, '0);
                check_value("illegal ctrl", 64'(e_out.ctrl), 64'd0);
        end
endtask

`endif

// File: riscv_de_tb_model.svh
`ifndef RISCV_DE_TB_MODEL_SVH
`define RISCV_DE_TB_MODEL_SVH

// controls as the decode rules give them, from raw instruction bits
function automatic riscv_de_pkg::riscv_de_ctrl_s expected_ctrl(input logic [31:0] w);
        riscv_de_pkg::riscv_de_ctrl_s   c;
        logic [6:0]                     op;
        logic [2:0]                     f3;
        logic [6:0]                     f7;
        logic                           word;
        c    = '0;
        op   = w[6:0];
        f3   = w[14:12];
        f7   = w[31:25];
        word = (op == `RISCV_DE_OP_OP32) || (op == `RISCV_DE_OP_OPIMM32);
        case (op)
        `RISCV_DE_OP_OP, `RISCV_DE_OP_OP32:
        begin
                c.regwrite      = 1'b1;
                c.alucontrol[4] = word;
                if (f7 == 7'd1)
                begin
                        if (f3 < 3'd4)
                        begin
                                c.funcsel = 2'b01;
                                c.mulctrl = f3;
                        end
                        else
                        begin
                                c.funcsel = 2'b10;
                                c.divctrl = f3 - 3'd4;
                        end
                end
                else
                begin
                        c.alucontrol[3]   = f7[5];
                        c.alucontrol[2:0] = f3;
                end
        end
        `RISCV_DE_OP_OPIMM, `RISCV_DE_OP_OPIMM32:
        begin
                c.regwrite        = 1'b1;
                c.oprnd2sel       = 1'b1;
                c.alucontrol[4]   = word;
                c.alucontrol[3]   = (f3 == 3'b101) && f7[5];    // arithmetic shift only
                c.alucontrol[2:0] = f3;
        end
        `RISCV_DE_OP_LOAD:
        begin
                c.regwrite  = 1'b1;
                c.oprnd2sel = 1'b1;
                c.resultsrc = 2'b01;
                c.memext    = f3;
        end
        `RISCV_DE_OP_STORE:
        begin
                c.memwrite  = 1'b1;
                c.oprnd2sel = 1'b1;
                c.storesrc  = f3[1:0];
        end
        `RISCV_DE_OP_BRANCH:
                c.b_condition = {1'b1, f3};
        `RISCV_DE_OP_JAL, `RISCV_DE_OP_JALR:
        begin
                c.jump      = 1'b1;
                c.regwrite  = 1'b1;
                c.resultsrc = 2'b10;
                c.oprnd1sel = (op == `RISCV_DE_OP_JAL);
        end
        `RISCV_DE_OP_LUI:
        begin
                c.regwrite      = 1'b1;
                c.oprnd2sel     = 1'b1;
                c.alucontrol[5] = 1'b1;
        end
        `RISCV_DE_OP_AUIPC:
        begin
                c.regwrite  = 1'b1;
                c.oprnd1sel = 1'b1;
                c.oprnd2sel = 1'b1;
        end
        default:
                c = '0;
        endcase
        return c;
endfunction

function automatic logic [63:0] expected_imm(input logic [31:0] w);
        case (w[6:0])
        `RISCV_DE_OP_OPIMM, `RISCV_DE_OP_OPIMM32, `RISCV_DE_OP_LOAD, `RISCV_DE_OP_JALR:
                return {{52{w[31]}}, w[31:20]};
        `RISCV_DE_OP_STORE:
                return {{52{w[31]}}, w[31:25], w[11:7]};
        `RISCV_DE_OP_BRANCH:
                return {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        `RISCV_DE_OP_LUI, `RISCV_DE_OP_AUIPC:
                return {{32{w[31]}}, w[31:12], 12'b0};
        `RISCV_DE_OP_JAL:
                return {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        default:
                return '0;
        endcase
endfunction

function automatic riscv_de_pkg::riscv_de_de_s expected_bundle(input logic [31:0] w,
        input logic [15:0] c16, input logic [63:0] p, input logic [63:0] p4);
        riscv_de_pkg::riscv_de_de_s b;
        b             = '0;
        b.pc          = p;
        b.pcplus4     = p4;
        b.rs1addr     = w[19:15];
        b.rs1data     = shadow[w[19:15]];
        b.rs2addr     = w[24:20];
        b.rs2data     = shadow[w[24:20]];
        b.rdaddr      = w[11:7];
        b.extendedimm = expected_imm(w);
        b.opcode      = w[6:0];
        b.ctrl        = expected_ctrl(w);
        b.inst        = w;
        b.cinst       = c16;
        return b;
endfunction

`endif

// File: riscv_de_tb.sv
`timescale 1ns/100ps
`include "riscv_de_consts.svh"

module riscv_de_tb;

        localparam int XL         = `RISCV_DE_XLEN;
        localparam int MAX_CYCLES = 1000;               // directed tests need about 300

        logic                           clk;
        logic                           rst;
        riscv_de_pkg::riscv_de_inst_u   inst;
        logic [15:0]                    cinst;
        logic [XL-1:0]                  pc;
        logic [XL-1:0]                  pcplus4;
        logic                           flush;
        riscv_de_pkg::riscv_de_wb_s     wb;
        riscv_de_pkg::riscv_de_de_s     e_out;

        logic [XL-1:0]  shadow [0:`RISCV_DE_NREGS-1];   // x0 entry stays zero
        int             errors = 0;
        int             checks = 0;
        int             cycles = 0;

        riscv_de_stage u_dut (
                .i_riscv_de_clk         (clk),
                .i_riscv_de_rst         (rst),
                .i_riscv_de_inst        (inst),
                .i_riscv_de_cinst       (cinst),
                .i_riscv_de_pc          (pc),
                .i_riscv_de_pcplus4     (pcplus4),
                .i_riscv_de_flush       (flush),
                .i_riscv_de_wb          (wb),
                .o_riscv_de_e           (e_out)
        );

        always #2 clk = ~clk;

        always @(posedge clk)
        begin
                cycles++;
                if (cycles >= MAX_CYCLES)
                begin
                        $display("run stopped, cycle limit of %0d reached", MAX_CYCLES);
                        $display(">>> FAIL");
                        $finish;
                end
        end

        task automatic check_value(input string what, input logic [63:0] got,
                                   input logic [63:0] exp);
                checks++;
                assert (got === exp)
                else
                begin
                        errors++;
                        $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
                end
        endtask

        task automatic check_bundle(input riscv_de_pkg::riscv_de_de_s exp);
                check_value("pc", e_out.pc, exp.pc);
                check_value("pcplus4", e_out.pcplus4, exp.pcplus4);
                check_value("rs1addr", 64'(e_out.rs1addr), 64'(exp.rs1addr));
                check_value("rs1data", e_out.rs1data, exp.rs1data);
                check_value("rs2addr", 64'(e_out.rs2addr), 64'(exp.rs2addr));
                check_value("rs2data", e_out.rs2data, exp.rs2data);
                check_value("rdaddr", 64'(e_out.rdaddr), 64'(exp.rdaddr));
                check_value("extendedimm", e_out.extendedimm, exp.extendedimm);
                check_value("opcode", 64'(e_out.opcode), 64'(exp.opcode));
                check_value("ctrl", 64'(e_out.ctrl), 64'(exp.ctrl));
                check_value("inst", 64'(e_out.inst), 64'(exp.inst));
                check_value("cinst", 64'(e_out.cinst), 64'(exp.cinst));
        endtask

        `include "riscv_de_tb_model.svh"

        // drive one word on the falling edge and check it after the next rising edge
        task automatic issue(input logic [31:0] w, input logic fl, input logic wr,
                             input logic [4:0] wrd, input logic [63:0] wdata);
                riscv_de_pkg::riscv_de_de_s     exp;
                logic [XL-1:0]                  p;
                p       = {32'($urandom), 30'($urandom), 2'b00};
                inst    = w;
                cinst   = 16'($urandom);
                pc      = p;
                pcplus4 = p + 64'd4;
                flush   = fl;
                wb      = '{regwrite: wr, rdaddr: wrd, data: wdata};
                if (wr && (wrd != 5'd0))
                        shadow[wrd] = wdata;            // bypass makes it visible now
                if (fl)
                        exp = '0;
                else
                        exp = expected_bundle(w, cinst, p, p + 64'd4);
                @(posedge clk);
                @(negedge clk);
                wb    = '0;
                flush = 1'b0;
                check_bundle(exp);
        endtask

        function automatic logic [31:0] rand_word(input logic [6:0] op);
                return {25'($urandom), op};
        endfunction

        `include "riscv_de_tb_tests.svh"

        initial
        begin
                void'($urandom(39923));
                clk     = 1'b0;
                rst     = 1'b1;
                inst    = '0;
                cinst   = '0;
                pc      = '0;
                pcplus4 = '0;
                flush   = 1'b0;
                wb      = '0;
                for (int k = 0; k < `RISCV_DE_NREGS; k++)
                        shadow[k] = '0;
                repeat (8) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                test_reset();
                test_regfile();
                test_formats();
                test_muldiv();
                test_flush();
                test_illegal();
                $display("checks run %0d, errors %0d, cycles %0d", checks, errors, cycles);
                if (errors == 0)
                        $display(">>> PASS");
                else
                        $display(">>> FAIL");
                $finish;
        end

endmodule

// File: flist.f
+incdir+.
riscv_de_pkg.sv
riscv_de_ctrl_dec.sv
riscv_de_immext.sv
riscv_de_regfile.sv
riscv_de_ppreg.sv
riscv_de_stage.sv
riscv_de_tb.sv

// File: Makefile
# Verilator simulation of the decode stage testbench

VERILATOR ?= verilator
TOP       ?= riscv_de_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
